// ==== tinyCore.f ====
verilog/coreTypes.sv
verilog/decodeIf.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/aluExec.sv
verilog/coreSequencer.sv
verilog/tinyCore.sv
verification/tinyCoreTb.sv

// ==== Makefile ====
# Verilator flow for tinyCore

VERILATOR ?= verilator
TOP       ?= tinyCoreTb
RTL_TOP   ?= tinyCore
FILELIST  ?= tinyCore.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Build, run, then look for the pass line in the captured output
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/tinyCoreTb.sv ====
`timescale 1ns/1ps

module tinyCoreTb import coreTypes::*; ();

    localparam int timeoutCycles = 200;

    logic clk;
    logic reset_n;
    logic halt;
    logic trap;
    wordT iAddr;
    wordT iData;
    wordT dAddr;
    wordT dIn;
    wordT dOut;
    logic memRw;
    logic strobe;

    wordT imem [0:255];
    wordT dmem [0:255];
    logic [15:0] lfsrState = 16'd64;
    int errorCount = 0;
    int checkCount = 0;

    tinyCore #(
        .RESET_VECTOR   (32'd0),
        .VECTOR_BASE    (32'd64),
        .TRAMP_BOTTOM   (32'd200),
        .TRAP_SAVE_ADDR (32'd96)
    ) UUT (.*);

    assign iData = imem[iAddr[7:0]];
    assign dIn   = dmem[dAddr[7:0]];

    // Refill on reset, so each program starts from the same data image
    always @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (strobe && memRw) begin
            dmem[dAddr[7:0]] <= dOut;
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic wordT fillWord(int index);
        return 32'h0000_0100 + index;   // Low byte points back at imem[index]
    endfunction

    function automatic wordT signExt(immT value);
        return {{20{value[11]}}, value};
    endfunction

    function automatic wordT encode(logic throwBit, logic kind, logic storing, logic deref,
                                    regIndexT dest, regIndexT x, regIndexT y,
                                    aluOpT op, immT imm);
        return {throwBit, kind, storing, deref, dest, x, y, op, imm};
    endfunction

    function automatic wordT loadImm(regIndexT dest, immT imm);
        return encode(1'b0, 1'b0, 1'b0, 1'b0, dest, 4'd0, 4'd0, opAdd, imm);
    endfunction

    function automatic wordT storeAt(regIndexT src, immT addr);
        return encode(1'b0, 1'b0, 1'b1, 1'b0, src, 4'd0, 4'd0, opOr, addr);
    endfunction

    function automatic wordT jumpTo(immT target);
        return encode(1'b0, 1'b0, 1'b0, 1'b0, pcIndex, 4'd0, 4'd0, opOr, target);
    endfunction

    // Kind bit trades Y and the immediate between operand and addend
    function automatic wordT refAlu(aluOpT op, logic swap, wordT x, wordT y, immT imm);
        wordT a;
        wordT b;
        wordT r;
        a = swap ? signExt(imm) : y;
        b = swap ? y : signExt(imm);
        case (op)
            opOr:     r = x | a;
            opAnd:    r = x & a;
            opAdd:    r = x + a;
            opMul:    r = x * a;
            opShl:    r = x << a;
            opLt:     r = ($signed(x) < $signed(a)) ? 32'hFFFF_FFFF : 32'h0;
            opEq:     r = (x == a) ? 32'hFFFF_FFFF : 32'h0;
            opGt:     r = ($signed(x) > $signed(a)) ? 32'hFFFF_FFFF : 32'h0;
            opAndNot: r = x & ~a;
            opXor:    r = x ^ a;
            opSub:    r = x - a;
            opXnor:   r = ~(x ^ a);
            opShr:    r = x >> a;
            opNe:     r = (x != a) ? 32'hFFFF_FFFF : 32'h0;
            default:  r = 32'h0;    // Reserved codes
        endcase
        return r + b;
    endfunction

    function automatic immT randomImm();
        immT value;
        logic outBit;
        value = '0;
        for (int i = 0; i < 12; i++) begin
            outBit = lfsrState[0];
            lfsrState = {1'b0, lfsrState[15:1]} ^ (outBit ? 16'hB400 : 16'h0000);
            value = {value[10:0], outBit};
        end
        return value;
    endfunction

    task automatic checkWord(string what, wordT got, wordT expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic checkAddr(string what, wordT got, wordT expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic checkBit(string what, logic got, logic expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, what, got, expected);
        end
    endtask

    // Imem is loaded at the negedge while reset is held
    task automatic holdReset();
        @(posedge clk) reset_n <= 1'b0;
        @(negedge clk);
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
    endtask

    task automatic releaseReset();
        @(posedge clk);
        @(posedge clk) reset_n <= 1'b1;
    endtask

    task automatic waitStore(output wordT addr, output wordT data);
        int cycles;
        logic found;
        cycles = 0;
        found = 1'b0;
        addr = '0;
        data = '0;
        while (!found && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
            if (strobe && memRw) begin
                found = 1'b1;
                addr = dAddr;
                data = dOut;
            end
        end
        if (!found) begin
            errorCount++;
            $display("Timeout at %0t: no memory write in %0d cycles", $time, timeoutCycles);
        end
    endtask

    task automatic waitIAddrChange(output wordT newAddr);
        wordT startAddr;
        int cycles;
        startAddr = iAddr;
        newAddr = iAddr;
        cycles = 0;
        while (newAddr == startAddr && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
            newAddr = iAddr;
        end
        if (newAddr == startAddr) begin
            errorCount++;
            $display("Timeout at %0t: iAddr stuck at %0d", $time, startAddr);
        end
    endtask

    task automatic aluCase(aluOpT op, logic swap);
        immT immX;
        immT immY;
        immT immC;
        wordT addr;
        wordT data;
        immX = randomImm();
        immY = randomImm();
        immC = randomImm();
        if (op == opShl || op == opShr) begin
            immY = swap ? immY : (immY & 12'h01F);  // Keep shift counts useful
            immC = swap ? (immC & 12'h01F) : immC;
        end
        if ((op == opEq || op == opNe) && !swap) begin
            immY = immX;    // Equal operands give the true case
        end
        holdReset();
        imem[0] = loadImm(4'd1, immX);
        imem[1] = loadImm(4'd2, immY);
        imem[2] = encode(1'b0, swap, 1'b0, 1'b0, 4'd3, 4'd1, 4'd2, op, immC);
        imem[3] = storeAt(4'd3, 12'd32);
        imem[4] = jumpTo(12'd4);
        releaseReset();
        waitStore(addr, data);
        checkAddr("dAddr", addr, 32'd32);
        checkWord($sformatf("dOut for %s", op.name()), data,
                  refAlu(op, swap, signExt(immX), signExt(immY), immC));
    endtask

    task automatic zeroRegStays();
        wordT addr;
        wordT data;
        holdReset();
        imem[0] = loadImm(4'd0, 12'h123);
        imem[1] = storeAt(4'd0, 12'd33);
        imem[2] = jumpTo(12'd2);
        releaseReset();
        waitStore(addr, data);
        checkAddr("dAddr", addr, 32'd33);
        checkWord("r0", data, 32'd0);
    endtask

    task automatic storeThenLoad();
        immT value;
        wordT addr;
        wordT data;
        value = randomImm();
        holdReset();
        imem[0] = loadImm(4'd1, value);
        imem[1] = loadImm(4'd2, 12'd40);
        imem[2] = encode(1'b0, 1'b0, 1'b1, 1'b1, 4'd1, 4'd2, 4'd0, opAdd, 12'd5);
        imem[3] = encode(1'b0, 1'b0, 1'b0, 1'b1, 4'd4, 4'd2, 4'd0, opAdd, 12'd5);
        imem[4] = storeAt(4'd4, 12'd46);
        imem[5] = jumpTo(12'd5);
        releaseReset();
        waitStore(addr, data);
        checkAddr("store dAddr", addr, refAlu(opAdd, 1'b0, 32'd40, 32'd0, 12'd5));
        checkWord("store dOut", data, signExt(value));
        waitStore(addr, data);
        checkAddr("reload dAddr", addr, 32'd46);
        checkWord("reload dOut", data, signExt(value));
    endtask

    task automatic branchByPc();
        wordT addr;
        wordT data;
        holdReset();
        imem[0] = loadImm(4'd1, 12'd10);
        imem[1] = encode(1'b0, 1'b0, 1'b0, 1'b0, pcIndex, 4'd1, 4'd0, opAdd, 12'd7);
        imem[2] = storeAt(4'd1, 12'd50);     // Skipped by the jump
        imem[17] = storeAt(4'd1, 12'd52);
        imem[18] = jumpTo(12'd18);
        releaseReset();
        waitIAddrChange(addr);
        checkAddr("iAddr", addr, 32'd1);
        waitIAddrChange(addr);
        checkAddr("branch target", addr, refAlu(opAdd, 1'b0, 32'd10, 32'd0, 12'd7));
        waitStore(addr, data);
        checkAddr("dAddr after branch", addr, 32'd52);
    endtask

    task automatic softwareThrow();
        wordT addr;
        wordT data;
        holdReset();
        imem[0] = loadImm(4'd1, 12'h2B1);
        imem[1] = encode(1'b1, 1'b1, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, opOr, 12'd3);
        imem[67] = storeAt(4'd1, 12'd55);    // Handler
        imem[68] = jumpTo(12'h144);
        releaseReset();
        waitIAddrChange(addr);
        checkAddr("throw iAddr", addr, 32'd1);
        waitStore(addr, data);
        checkAddr("save dAddr", addr, 32'd96);
        checkWord("saved iAddr", data, 32'd1);
        waitIAddrChange(addr);
        checkAddr("handler iAddr", addr, fillWord(64 | 3));
        waitStore(addr, data);
        checkAddr("handler dAddr", addr, 32'd55);
        checkWord("handler dOut", data, signExt(12'h2B1));
    endtask

    task automatic externalTrap();
        wordT addr;
        wordT data;
        holdReset();
        imem[0] = jumpTo(12'd0);
        imem[200] = jumpTo(12'd200);
        releaseReset();
        trap <= 1'b1;
        waitStore(addr, data);
        checkAddr("save dAddr", addr, 32'd96);
        checkWord("saved iAddr", data, 32'd0);
        waitIAddrChange(addr);
        checkAddr("trampoline iAddr", addr, 32'd200);
        @(posedge clk) trap <= 1'b0;
    endtask

    task automatic haltAfterReset();
        wordT addr;
        wordT data;
        @(posedge clk) halt <= 1'b1;
        holdReset();
        imem[0] = loadImm(4'd1, 12'h05A);
        imem[1] = storeAt(4'd1, 12'd58);
        imem[2] = jumpTo(12'd2);
        releaseReset();
        repeat (20) begin
            @(negedge clk);
            checkBit("strobe", strobe, 1'b0);
            checkBit("memRw", memRw, 1'b0);
            checkAddr("iAddr", iAddr, 32'd0);
        end
        @(posedge clk) halt <= 1'b0;
        waitIAddrChange(addr);
        checkAddr("first iAddr step", addr, 32'd1);
        waitStore(addr, data);
        checkWord("dOut", data, 32'h0000_005A);
    endtask

    initial begin
        reset_n = 1'b0;
        halt = 1'b0;
        trap = 1'b0;
        for (int i = 0; i < 16; i++) begin
            aluCase(aluOpT'(i[3:0]), 1'b0);
            aluCase(aluOpT'(i[3:0]), 1'b1);
        end
        zeroRegStays();
        storeThenLoad();
        branchByPc();
        softwareThrow();
        externalTrap();
        haltAfterReset();
        $display("checks: %0d  errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== verilog/tinyCore.sv ====
`timescale 1ns/1ps

module tinyCore import coreTypes::*; #(
    parameter wordT RESET_VECTOR   = 32'h0000_0000,
    parameter wordT VECTOR_BASE    = 32'h0000_0040,
    parameter wordT TRAMP_BOTTOM   = 32'h0000_00c8,
    parameter wordT TRAP_SAVE_ADDR = 32'h0000_0060
) (
    input  logic clk,
    input  logic reset_n,
    input  logic halt,
    input  logic trap,
    output wordT iAddr,
    input  wordT iData,
    output wordT dAddr,
    input  wordT dIn,
    output wordT dOut,
    output logic memRw,
    output logic strobe
);

    wordT valueX;
    wordT valueY;
    wordT valueZ;
    wordT aluResult;
    wordT writeData;
    wordT nextPc;
    logic decodeEnable;
    logic aluEnable;
    logic regWrite;

    decodeIf decBus ();

    instrDecode uDecode (
        .insn   (iData),
        .enable (decodeEnable),
        .dec    (decBus)
    );

    // Register reads run beside the decoder on the same fetched word
    regFile uRegs (
        .clk       (clk),
        .readX     (decBus.srcX),
        .readY     (decBus.srcY),
        .readZ     (decBus.dest),
        .valueX    (valueX),
        .valueY    (valueY),
        .valueZ    (valueZ),
        .writeEn   (regWrite),
        .writeData (writeData),
        .nextPc    (nextPc)
    );

    aluExec uAlu (
        .clk    (clk),
        .enable (aluEnable),
        .dec    (decBus),
        .valueX (valueX),
        .valueY (valueY),
        .result (aluResult)
    );

    coreSequencer #(
        .RESET_VECTOR   (RESET_VECTOR),
        .VECTOR_BASE    (VECTOR_BASE),
        .TRAMP_BOTTOM   (TRAMP_BOTTOM),
        .TRAP_SAVE_ADDR (TRAP_SAVE_ADDR)
    ) uSeq (
        .clk          (clk),
        .reset_n      (reset_n),
        .halt         (halt),
        .trap         (trap),
        .dec          (decBus),
        .aluResult    (aluResult),
        .dIn          (dIn),
        .valueZ       (valueZ),
        .iAddr        (iAddr),
        .nextPc       (nextPc),
        .decodeEnable (decodeEnable),
        .aluEnable    (aluEnable),
        .regWrite     (regWrite),
        .writeData    (writeData),
        .dAddr        (dAddr),
        .dOut         (dOut),
        .memRw        (memRw),
        .strobe       (strobe)
    );

endmodule

// ==== verilog/coreSequencer.sv ====
`timescale 1ns/1ps

module coreSequencer import coreTypes::*; #(
    parameter wordT RESET_VECTOR   = 32'h0000_0000,
    parameter wordT VECTOR_BASE    = 32'h0000_0040,
    parameter wordT TRAMP_BOTTOM   = 32'h0000_00c8,
    parameter wordT TRAP_SAVE_ADDR = 32'h0000_0060
) (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    halt,
    input  logic    trap,
    decodeIf.seq    dec,
    input  wordT    aluResult,
    input  wordT    dIn,
    input  wordT    valueZ,
    output wordT    iAddr,
    output wordT    nextPc,
    output logic    decodeEnable,
    output logic    aluEnable,
    output logic    regWrite,
    output wordT    writeData,
    output wordT    dAddr,
    output wordT    dOut,
    output logic    memRw,
    output logic    strobe
);

    coreStateT state;
    coreStateT stateNext;
    wordT      resultQ;     // ALU result, table address or return address
    wordT      loadQ;
    wordT      vectorQ;     // Jump target for trap entry
    logic      loading;
    logic      trapWrite;

    always_comb begin
        stateNext = state;
        unique case (state)
            stIdle:    stateNext = halt ? stIdle : stFetch;
            stExec: begin
                if (halt) begin
                    stateNext = stIdle;
                end else if (trap) begin
                    stateNext = stTrapIn;
                end else if (dec.throwReq) begin
                    stateNext = stThrow;
                end else begin
                    stateNext = stLatch;
                end
            end
            stLatch:   stateNext = stMulWait;
            stMulWait: stateNext = stMem;       // Room for the multiplier
            stMem:     stateNext = stCommit;
            stCommit:  stateNext = stFetch;
            stFetch:   stateNext = stExec;
            stThrow:   stateNext = stVecRead;
            stVecRead: stateNext = stSaveRet;
            stTrapIn:  stateNext = stSaveRet;
            stSaveRet: stateNext = stVecJump;
            stVecJump: stateNext = stFetch;
            default:   stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state  <= stIdle;
            iAddr  <= RESET_VECTOR;
            nextPc <= RESET_VECTOR + 32'd1;
        end else begin
            state <= stateNext;
            case (state)
                stIdle:    iAddr  <= RESET_VECTOR;
                stCommit:  iAddr  <= dec.branch ? writeData : nextPc;
                stVecJump: iAddr  <= vectorQ;
                stFetch:   nextPc <= iAddr + 32'd1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            stLatch:   resultQ <= aluResult;
            stMem:     loadQ   <= dIn;
            stThrow:   resultQ <= VECTOR_BASE | {27'd0, dec.vector};
            stVecRead: vectorQ <= dIn;              // Handler address from table
            stTrapIn:  vectorQ <= TRAMP_BOTTOM;
            stSaveRet: resultQ <= iAddr;            // Return to the trapped insn
            default: ;
        endcase
    end

    assign decodeEnable = (state != stFetch);   // Fields stay zero while iAddr moves
    assign aluEnable    = (state == stExec);
    assign loading      = dec.derefRhs & ~dec.storing;

    assign regWrite  = (state == stCommit) & ~dec.storing;
    assign writeData = dec.derefRhs ? loadQ : resultQ;

    assign trapWrite = (state == stSaveRet) || (state == stVecJump);
    assign dAddr     = trapWrite ? TRAP_SAVE_ADDR : resultQ;
    assign dOut      = trapWrite ? resultQ : valueZ;

    assign strobe = ((state == stMem) & (loading | dec.storing)) | (state == stVecJump);
    assign memRw  = ((state == stMem) & dec.storing) | (state == stVecJump);

endmodule

// ==== verilog/aluExec.sv ====
`timescale 1ns/1ps

module aluExec import coreTypes::*; (
    input  logic    clk,
    input  logic    enable,
    decodeIf.alu    dec,
    input  wordT    valueX,
    input  wordT    valueY,
    output wordT    result
);

    wordT immExt;
    wordT operand;
    wordT addend;
    wordT base;
    logic lessThan;
    logic greaterThan;

    assign immExt = {{20{dec.imm[11]}}, dec.imm};   // Sign extension

    // Kind bit exchanges immediate and Y
    assign operand = dec.swap ? immExt : valueY;
    assign addend  = dec.swap ? valueY : immExt;

    assign lessThan    = $signed(valueX) < $signed(operand);
    assign greaterThan = $signed(valueX) > $signed(operand);

    always_comb begin
        base = '0;
        unique case (dec.op)
            opOr:     base = valueX | operand;
            opAnd:    base = valueX & operand;
            opAdd:    base = valueX + operand;
            opMul:    base = valueX * operand;
            opShl:    base = valueX << operand;     // Full operand as shift count
            opLt:     base = {32{lessThan}};        // True reads as minus one
            opEq:     base = {32{valueX == operand}};
            opGt:     base = {32{greaterThan}};
            opAndNot: base = valueX & ~operand;
            opXor:    base = valueX ^ operand;
            opSub:    base = valueX - operand;
            opXnor:   base = valueX ^~ operand;
            opShr:    base = valueX >> operand;     // Logical
            opNe:     base = {32{valueX != operand}};
            opRsvd4,
            opRsvd15: base = '0;                    // Addend alone
        endcase
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result <= base + addend;
        end
    end

endmodule

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps

module regFile import coreTypes::*; (
    input  logic     clk,
    input  regIndexT readX,
    input  regIndexT readY,
    input  regIndexT readZ,
    output wordT     valueX,
    output wordT     valueY,
    output wordT     valueZ,
    input  logic     writeEn,
    input  wordT     writeData,
    input  wordT     nextPc
);

    // Entry 0 is never written, so it keeps reading zero
    wordT store [0:14] = '{default: '0};

    logic writeOk;

    assign valueX = (readX == pcIndex) ? nextPc : store[readX];
    assign valueY = (readY == pcIndex) ? nextPc : store[readY];
    assign valueZ = (readZ == pcIndex) ? nextPc : store[readZ];

    assign writeOk = writeEn && (readZ != '0) && (readZ != pcIndex);   // Skip r0 and PC

    always_ff @(posedge clk) begin
        if (writeOk) begin
            store[readZ] <= writeData;  // Destination doubles as Z read port
        end
    end

endmodule

// ==== verilog/instrDecode.sv ====
`timescale 1ns/1ps

module instrDecode import coreTypes::*; (
    input  wordT     insn,
    input  logic     enable,
    decodeIf.producer dec
);

    wordT gated;    // Instruction word, zero while disabled

    assign gated = enable ? insn : '0;

    assign dec.swap     = gated[30];
    assign dec.storing  = gated[29];
    assign dec.derefRhs = gated[28];
    assign dec.dest     = gated[27:24];
    assign dec.srcX     = gated[23:20];
    assign dec.srcY     = gated[19:16];
    assign dec.op       = aluOpT'(gated[15:12]);
    assign dec.imm      = gated[11:0];
    assign dec.vector   = gated[4:0];   // Overlaps the immediate

    // Both top bits set marks a software throw
    assign dec.throwReq = gated[31] & gated[30];

    // Writing the program counter is a jump, unless it goes to memory
    assign dec.branch = (gated[27:24] == pcIndex) & ~gated[29];

endmodule

// ==== verilog/decodeIf.sv ====
`timescale 1ns/1ps

interface decodeIf import coreTypes::*; ();

    regIndexT   dest;
    regIndexT   srcX;
    regIndexT   srcY;
    immT        imm;
    aluOpT      op;
    logic       swap;       // Kind bit
    logic       storing;
    logic       derefRhs;
    logic       branch;
    logic       throwReq;
    logic [4:0] vector;

    modport producer (
        output dest, srcX, srcY, imm, op, swap,
        output storing, derefRhs, branch, throwReq, vector
    );

    modport alu (input op, swap, imm);

    modport seq (input storing, derefRhs, branch, throwReq, vector);

    modport rf (input dest, srcX, srcY);

endinterface

// ==== verilog/coreTypes.sv ====
package coreTypes;

    typedef logic [31:0] wordT;        // Machine word
    typedef logic [3:0]  regIndexT;    // Register number
    typedef logic [11:0] immT;         // Raw immediate field

    localparam regIndexT pcIndex = 4'd15;  // Program counter alias

    typedef enum logic [3:0] {
        opOr      = 4'd0,
        opAnd     = 4'd1,
        opAdd     = 4'd2,
        opMul     = 4'd3,
        opRsvd4   = 4'd4,
        opShl     = 4'd5,
        opLt      = 4'd6,
        opEq      = 4'd7,
        opGt      = 4'd8,
        opAndNot  = 4'd9,
        opXor     = 4'd10,
        opSub     = 4'd11,
        opXnor    = 4'd12,
        opShr     = 4'd13,
        opNe      = 4'd14,
        opRsvd15  = 4'd15
    } aluOpT;

    // Each instruction walks stExec through stFetch
    typedef enum logic [3:0] {
        stIdle,
        stExec,
        stLatch,
        stMulWait,
        stMem,
        stCommit,
        stFetch,
        stThrow,
        stTrapIn,
        stVecRead,
        stSaveRet,
        stVecJump
    } coreStateT;

endpackage
